/* common/core_settings.svh */
// widths follow the RV32I encoding; the tag only has to outlast the few items in flight after a branch
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ========================================
// core dimensions
// ========================================

// data path and address width in bits
`define CORE_XLEN       32

// architectural integer registers, x0 included
`define CORE_REG_COUNT  32

// flow tag width, bumped by fetch and by retire on every taken branch
`define CORE_TAG_WIDTH  3

// address of the first instruction fetched after reset
`define CORE_RESET_PC   32'h0000_0000

`endif

/* common/core_pkg.sv */
// reduced RV32I subset only; every encoding outside it decodes to OP_NOP and retires with no effect
package core_pkg;

`include "core_settings.svh"

    // ========================================
    // operations
    // ========================================

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_LUI  = 4'd7,
        OP_BEQ  = 4'd8,
        OP_BNE  = 4'd9,
        OP_SW   = 4'd10
    } op_e;

    // ========================================
    // stage payloads
    // ========================================

    // branches carry their own pc in store_data
    // no store happens on a branch so the field is free there
    typedef struct packed {
        op_e                    op;
        logic [`CORE_XLEN-1:0]  operand_a;
        logic [`CORE_XLEN-1:0]  operand_b;
        logic [`CORE_XLEN-1:0]  store_data;
        logic [`CORE_XLEN-1:0]  imm;
    } decoded_t;

    // result is the ALU value, the store address or the branch target
    typedef struct packed {
        op_e                    op;
        logic [`CORE_XLEN-1:0]  result;
        logic [`CORE_XLEN-1:0]  store_data;
        logic                   branch_taken;
    } retired_t;

    // operations that end with a register write
    function automatic logic op_writes_reg(op_e op);
        case (op)
            OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

/* common/stage_if.sv */
// no handshake on this link; the consumer takes a new item at every edge where stall is low
`include "core_settings.svh"

interface stage_if #(
    parameter type payload_t = logic
);

    logic                        valid;
    logic [`CORE_TAG_WIDTH-1:0]  tag;
    // destination register travels beside the payload so hazard checks can read it directly
    logic [4:0]                  rd;
    payload_t                    payload;

    modport producer (output valid, tag, rd, payload);

    modport consumer (input valid, tag, rd, payload);

endinterface

/* decode/regbank.sv */
// 5-bit indices assume 32 entries; x0 is never written and always reads zero
`include "core_settings.svh"

module regbank (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1_i,
    input  logic [4:0]             rs2_i,
    input  logic [4:0]             rd_i,
    input  logic                   write_enable_i,
    input  logic [`CORE_XLEN-1:0]  data_i,
    output logic [`CORE_XLEN-1:0]  data1_o,
    output logic [`CORE_XLEN-1:0]  data2_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];
    logic                  writing;

    assign writing = write_enable_i && (rd_i != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end
        else if (writing) begin
            regs[rd_i] <= data_i;
        end
    end

    // a register being written this cycle reads back the new value
    assign data1_o = (writing && rd_i == rs1_i) ? data_i : regs[rs1_i];
    assign data2_o = (writing && rd_i == rs2_i) ? data_i : regs[rs2_i];

endmodule

/* decode/decode.sv */
// RV32I subset only; an instruction reading the result of the one just ahead waits one cycle
`include "core_settings.svh"

module decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall_i,
    input  logic [31:0]                 instruction_i,
    input  logic [`CORE_XLEN-1:0]       pc_i,
    input  logic [`CORE_TAG_WIDTH-1:0]  tag_i,
    input  logic                        wb_enable_i,
    input  logic [4:0]                  wb_rd_i,
    input  logic [`CORE_XLEN-1:0]       wb_data_i,
    output logic                        hazard_o,
    stage_if.producer                   to_exe_o
);

    logic [31:0]            instruction;
    logic [31:0]            held_instruction;
    logic                   replay;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [4:0]             rd;
    logic [`CORE_XLEN-1:0]  rs1_data;
    logic [`CORE_XLEN-1:0]  rs2_data;
    logic [`CORE_XLEN-1:0]  imm;
    core_pkg::op_e          op;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   is_branch;
    core_pkg::decoded_t     decoded;

    // ========================================
    // instruction word
    // ========================================

    // the memory moves on at a held edge, so the word under decode is kept here for the replay
    always_ff @(posedge clk) begin
        held_instruction <= instruction;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            replay <= 1'b0;
        end
        else begin
            replay <= stall_i || hazard_o;
        end
    end

    assign instruction = replay ? held_instruction : instruction_i;
    assign rs1         = instruction[19:15];
    assign rs2         = instruction[24:20];
    assign rd          = instruction[11:7];

    always_comb begin
        op  = core_pkg::OP_NOP;
        imm = '0;
        case (instruction[6:0])
            7'b0110111: begin
                op  = core_pkg::OP_LUI;
                imm = {instruction[31:12], 12'b0};
            end
            7'b0010011: begin
                if (instruction[14:12] == 3'b000) begin
                    op = core_pkg::OP_ADDI;
                end
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            7'b0110011: begin
                case ({instruction[31:25], instruction[14:12]})
                    10'b0000000_000: op = core_pkg::OP_ADD;
                    10'b0100000_000: op = core_pkg::OP_SUB;
                    10'b0000000_111: op = core_pkg::OP_AND;
                    10'b0000000_110: op = core_pkg::OP_OR;
                    10'b0000000_100: op = core_pkg::OP_XOR;
                    default:         op = core_pkg::OP_NOP;
                endcase
            end
            7'b1100011: begin
                if (instruction[14:12] == 3'b000) begin
                    op = core_pkg::OP_BEQ;
                end
                else if (instruction[14:12] == 3'b001) begin
                    op = core_pkg::OP_BNE;
                end
                imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            7'b0100011: begin
                if (instruction[14:12] == 3'b010) begin
                    op = core_pkg::OP_SW;
                end
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            default: begin
                op = core_pkg::OP_NOP;
            end
        endcase
    end

    assign is_branch = (op == core_pkg::OP_BEQ) || (op == core_pkg::OP_BNE);
    assign uses_rs1  = (op != core_pkg::OP_NOP) && (op != core_pkg::OP_LUI);
    assign uses_rs2  = uses_rs1 && (op != core_pkg::OP_ADDI);

    // ========================================
    // operands
    // ========================================

    regbank regbank1 (
        .clk            (clk),
        .reset          (reset),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rd_i           (wb_rd_i),
        .write_enable_i (wb_enable_i),
        .data_i         (wb_data_i),
        .data1_o        (rs1_data),
        .data2_o        (rs2_data)
    );

    always_comb begin
        decoded.op         = op;
        decoded.operand_a  = (op == core_pkg::OP_LUI) ? '0 : rs1_data;
        decoded.operand_b  = uses_rs2 ? rs2_data : imm;
        decoded.store_data = is_branch ? pc_i : rs2_data;
        decoded.imm        = imm;
    end

    // only the entry now in execute can be missing from the register reads
    assign hazard_o = to_exe_o.valid && core_pkg::op_writes_reg(to_exe_o.payload.op)
                      && (to_exe_o.rd != 5'd0)
                      && ((uses_rs1 && rs1 == to_exe_o.rd) || (uses_rs2 && rs2 == to_exe_o.rd));

    // ========================================
    // decode/execute register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            to_exe_o.valid <= 1'b0;
            to_exe_o.tag   <= '0;
        end
        else if (!stall_i) begin
            to_exe_o.valid <= !hazard_o;
            to_exe_o.tag   <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            to_exe_o.rd      <= rd;
            to_exe_o.payload <= decoded;
        end
    end

endmodule

/* verilog/fetch.sv */
// memory must answer one edge after the address; the first decode slot after reset is a dropped dummy
`include "core_settings.svh"

module fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall_i,
    input  logic                        hazard_i,
    input  logic                        jump_i,
    input  logic [`CORE_XLEN-1:0]       jump_target_i,
    output logic [`CORE_XLEN-1:0]       instruction_address_o,
    output logic [`CORE_XLEN-1:0]       pc_o,
    output logic [`CORE_TAG_WIDTH-1:0]  tag_o
);

    logic [`CORE_XLEN-1:0]      pc;
    logic [`CORE_TAG_WIDTH-1:0] tag;

    assign instruction_address_o = pc;

    // next address to fetch, and the flow it belongs to
    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= `CORE_RESET_PC;
            tag <= '0;
        end
        else if (!stall_i) begin
            if (jump_i) begin
                pc  <= jump_target_i;
                tag <= tag + 1'b1;
            end
            else if (!hazard_i) begin
                pc <= pc + 'd4;
            end
        end
    end

    // address and tag of the word that decode sees in the following cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o  <= `CORE_RESET_PC;
            // the memory already returns the reset word now, and it comes again next cycle
            // a stale tag makes retire drop this first copy
            tag_o <= '1;
        end
        else if (!stall_i && !hazard_i) begin
            pc_o  <= pc;
            tag_o <= tag;
        end
    end

endmodule

/* verilog/execute.sv */
// one ALU result per item; branch targets are taken from the pc carried in store_data
`include "core_settings.svh"

module execute (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_i,
    stage_if.consumer   from_dec_i,
    stage_if.producer   to_ret_o
);

    core_pkg::decoded_t     dec;
    core_pkg::retired_t     ret;
    logic [`CORE_XLEN-1:0]  sum;
    logic [`CORE_XLEN-1:0]  difference;
    logic                   operands_equal;

    assign dec            = from_dec_i.payload;
    assign sum            = dec.operand_a + dec.operand_b;
    assign difference     = dec.operand_a - dec.operand_b;
    assign operands_equal = (dec.operand_a == dec.operand_b);

    // ========================================
    // ALU and branch unit
    // ========================================

    always_comb begin
        ret.op           = dec.op;
        ret.store_data   = dec.store_data;
        ret.branch_taken = 1'b0;
        case (dec.op)
            // LUI arrives with a zero operand_a
            core_pkg::OP_ADDI, core_pkg::OP_ADD, core_pkg::OP_LUI: ret.result = sum;
            core_pkg::OP_SUB: ret.result = difference;
            core_pkg::OP_AND: ret.result = dec.operand_a & dec.operand_b;
            core_pkg::OP_OR:  ret.result = dec.operand_a | dec.operand_b;
            core_pkg::OP_XOR: ret.result = dec.operand_a ^ dec.operand_b;
            core_pkg::OP_SW:  ret.result = dec.operand_a + dec.imm;
            core_pkg::OP_BEQ: begin
                ret.result       = dec.store_data + dec.imm;
                ret.branch_taken = operands_equal;
            end
            core_pkg::OP_BNE: begin
                ret.result       = dec.store_data + dec.imm;
                ret.branch_taken = !operands_equal;
            end
            default: ret.result = '0;
        endcase
    end

    // ========================================
    // execute/retire register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            to_ret_o.valid <= 1'b0;
            to_ret_o.tag   <= '0;
        end
        else if (!stall_i) begin
            to_ret_o.valid <= from_dec_i.valid;
            to_ret_o.tag   <= from_dec_i.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            to_ret_o.rd      <= from_dec_i.rd;
            to_ret_o.payload <= ret;
        end
    end

endmodule

/* verilog/retire.sv */
// outputs are combinational from the execute register; every effect is held off while stall_i is high
`include "core_settings.svh"

module retire (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    stage_if.consumer              from_exe_i,
    output logic                   wb_enable_o,
    output logic [4:0]             wb_rd_o,
    output logic [`CORE_XLEN-1:0]  wb_data_o,
    output logic                   jump_o,
    output logic [`CORE_XLEN-1:0]  jump_target_o,
    output logic                   mem_write_o,
    output logic [`CORE_XLEN-1:0]  mem_address_o,
    output logic [`CORE_XLEN-1:0]  mem_data_o
);

    logic [`CORE_TAG_WIDTH-1:0] retire_tag;
    logic                       live;
    core_pkg::retired_t         ret;

    assign ret = from_exe_i.payload;

    // items fetched before the last taken branch still carry the old tag
    assign live = from_exe_i.valid && (from_exe_i.tag == retire_tag) && !stall_i;

    // ========================================
    // effects of a live item
    // ========================================

    assign wb_enable_o = live && core_pkg::op_writes_reg(ret.op);
    assign wb_rd_o     = from_exe_i.rd;
    assign wb_data_o   = ret.result;

    assign mem_write_o   = live && (ret.op == core_pkg::OP_SW);
    assign mem_address_o = {ret.result[`CORE_XLEN-1:2], 2'b00};
    assign mem_data_o    = ret.store_data;

    assign jump_o        = live && ret.branch_taken;
    assign jump_target_o = ret.result;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_tag <= '0;
        end
        else if (jump_o) begin
            retire_tag <= retire_tag + 1'b1;
        end
    end

endmodule

/* verilog/rv32_core.sv */
// no loads and full-word stores only; instruction_i must hold the word addressed one edge earlier
`include "core_settings.svh"

module rv32_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic [31:0]            instruction_i,
    output logic [`CORE_XLEN-1:0]  instruction_address_o,
    output logic                   mem_write_o,
    output logic [`CORE_XLEN-1:0]  mem_address_o,
    output logic [`CORE_XLEN-1:0]  mem_data_o
);

    logic [`CORE_XLEN-1:0]      pc_decode;
    logic [`CORE_TAG_WIDTH-1:0] tag_decode;
    logic                       hazard;
    logic                       jump;
    logic [`CORE_XLEN-1:0]      jump_target;
    logic                       wb_enable;
    logic [4:0]                 wb_rd;
    logic [`CORE_XLEN-1:0]      wb_data;

    stage_if #(.payload_t(core_pkg::decoded_t)) dec_to_exe ();
    stage_if #(.payload_t(core_pkg::retired_t)) exe_to_ret ();

    // ========================================
    // pipeline stages
    // ========================================

    fetch fetch1 (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    decode decode1 (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_decode),
        .wb_enable_i   (wb_enable),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .hazard_o      (hazard),
        .to_exe_o      (dec_to_exe.producer)
    );

    execute execute1 (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .from_dec_i (dec_to_exe.consumer),
        .to_ret_o   (exe_to_ret.producer)
    );

    // retire also closes the loops back to fetch and to the register bank
    retire retire1 (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .from_exe_i    (exe_to_ret.consumer),
        .wb_enable_o   (wb_enable),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .mem_write_o   (mem_write_o),
        .mem_address_o (mem_address_o),
        .mem_data_o    (mem_data_o)
    );

endmodule

/* verif/core_checker.sv */
// samples at the falling edge; every expected store must be queued before the first store retires
`include "core_settings.svh"

module core_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic [`CORE_XLEN-1:0]  instruction_address_i,
    input  logic                   mem_write_i,
    input  logic [`CORE_XLEN-1:0]  mem_address_i,
    input  logic [`CORE_XLEN-1:0]  mem_data_i,
    output int                     store_count_o,
    output int                     value_errors_o,
    output int                     sequence_errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`CORE_XLEN-1:0] expected_addr [$];
    logic [`CORE_XLEN-1:0] expected_data [$];
    logic                  was_reset = 1'b0;

    initial begin
        store_count_o     = 0;
        value_errors_o    = 0;
        sequence_errors_o = 0;
    end

    task add_expected(input logic [`CORE_XLEN-1:0] addr, input logic [`CORE_XLEN-1:0] data);
        expected_addr.push_back(addr);
        expected_data.push_back(data);
    endtask

    task report_mismatch(input string name, input logic [`CORE_XLEN-1:0] expected,
                         input logic [`CORE_XLEN-1:0] actual);
        $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        value_errors_o++;
    endtask

    // ========================================
    // checks
    // ========================================

    task check_reset_outputs;
        if (mem_write_i !== 1'b0) begin
            report_mismatch("mem_write_o", '0, {{(`CORE_XLEN-1){1'b0}}, mem_write_i});
        end
        if (instruction_address_i !== `CORE_RESET_PC) begin
            report_mismatch("instruction_address_o", `CORE_RESET_PC, instruction_address_i);
        end
    endtask

    // stores must come in file order, each exactly once
    task check_store;
        logic [`CORE_XLEN-1:0] want_addr;
        logic [`CORE_XLEN-1:0] want_data;
        if (expected_addr.size() == 0) begin
            $display("unexpected store of %h to address %h after the expected sequence ended",
                     mem_data_i, mem_address_i);
            sequence_errors_o++;
        end
        else begin
            want_addr = expected_addr.pop_front();
            want_data = expected_data.pop_front();
            if (mem_address_i !== want_addr) begin
                report_mismatch("mem_address_o", want_addr, mem_address_i);
            end
            if (mem_data_i !== want_data) begin
                report_mismatch("mem_data_o", want_data, mem_data_i);
            end
        end
        store_count_o++;
    endtask

    always @(negedge clk) begin
        if (reset) begin
            check_reset_outputs();
            was_reset = 1'b1;
        end
        else begin
            // the first cycle after reset still shows the reset address
            if (was_reset) begin
                check_reset_outputs();
            end
            was_reset = 1'b0;
            if ($isunknown(mem_write_i)) begin
                report_mismatch("mem_write_o", '0, {{(`CORE_XLEN-1){1'b0}}, mem_write_i});
            end
            else if (mem_write_i && stall_i) begin
                report_mismatch("mem_write_o during stall", '0, 'd1);
            end
            else if (mem_write_i) begin
                check_store();
            end
        end
    end

endmodule

/* verif/core_tb.sv */
// instruction memory holds 256 words from address 0; the input file path is relative to the project root
`include "core_settings.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS     = 256;
    localparam int STORE_TIMEOUT = 200;
    localparam int TAIL_CYCLES   = 50;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   stall_i = 1'b0;
    logic [31:0]            instruction_i = '0;
    logic [`CORE_XLEN-1:0]  instruction_address_o;
    logic                   mem_write_o;
    logic [`CORE_XLEN-1:0]  mem_address_o;
    logic [`CORE_XLEN-1:0]  mem_data_o;

    logic [31:0]            program_mem [MEM_WORDS];
    logic [31:0]            expected_addr [$];
    logic [31:0]            expected_data [$];
    logic [31:0]            fetch_addr = '0;
    int                     cycle_count = 0;
    int                     stores_seen;
    int                     value_errors;
    int                     sequence_errors;
    int                     load_errors = 0;
    int                     timeout_errors = 0;
    int                     total_errors;

    always #10 clk = ~clk;

    rv32_core uut (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .mem_write_o           (mem_write_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    core_checker store_checker (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .instruction_address_i (instruction_address_o),
        .mem_write_i           (mem_write_o),
        .mem_address_i         (mem_address_o),
        .mem_data_i            (mem_data_o),
        .store_count_o         (stores_seen),
        .value_errors_o        (value_errors),
        .sequence_errors_o     (sequence_errors)
    );

    // ========================================
    // instruction memory
    // ========================================

    // the custom-0 opcode makes an unloaded word run as a no-op
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ {18'd0, addr[6:0]}, 7'b0001011};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr[31:2] < MEM_WORDS) begin
            return program_mem[addr[31:2]];
        end
        return fill_word(addr);
    endfunction

    // synchronous memory with one cycle of latency, plus the random stall
    always @(posedge clk) begin
        #1;
        instruction_i = read_word(fetch_addr);
        fetch_addr    = instruction_address_o;
        cycle_count++;
        if (cycle_count == 1) begin
            void'($urandom(32'h9eca));
        end
        if (cycle_count > 12) begin
            stall_i = (($urandom % 4) == 0);
        end
        else begin
            stall_i = 1'b0;
        end
    end

    // ========================================
    // input file
    // ========================================

    task load_program;
        int          fd;
        int          c;
        int          count;
        int          words;
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] data;
        for (int i = 0; i < MEM_WORDS; i++) begin
            program_mem[i] = fill_word(i * 4);
        end
        fd = $fopen("verif/program_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verif/program_input.txt");
            load_errors++;
            return;
        end
        words = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end
            else if (c == "I") begin
                count = $fscanf(fd, "%h", word);
                if (count == 1 && words < MEM_WORDS) begin
                    program_mem[words] = word;
                    words++;
                end
                else begin
                    $display("error: bad or surplus program word after word %0d", words);
                    load_errors++;
                end
            end
            else if (c == "S") begin
                count = $fscanf(fd, "%h %h", addr, data);
                if (count == 2) begin
                    expected_addr.push_back(addr);
                    expected_data.push_back(data);
                    store_checker.add_expected(addr, data);
                end
                else begin
                    $display("error: store line %0d lacks an address or data", expected_addr.size());
                    load_errors++;
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (expected_addr.size() == 0) begin
            $display("error: the input file lists no expected store");
            load_errors++;
        end
    endtask

    // ========================================
    // sequence
    // ========================================

    task wait_for_stores;
        int cycles;
        for (int i = 0; i < expected_addr.size(); i++) begin
            cycles = 0;
            while (stores_seen <= i && cycles < STORE_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (stores_seen <= i) begin
                $display("timeout: store %0d of %0d (address %h, data %h) never came in %0d cycles",
                         i + 1, expected_addr.size(), expected_addr[i], expected_data[i],
                         STORE_TIMEOUT);
                timeout_errors++;
                return;
            end
        end
    endtask

    // the final self-loop keeps running while the checker watches for stray stores
    task run_tail;
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(posedge clk);
        end
    endtask

    initial begin
        load_program();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;
        if (load_errors == 0) begin
            wait_for_stores();
            if (timeout_errors == 0) begin
                run_tail();
            end
        end
        total_errors = value_errors + sequence_errors + timeout_errors + load_errors;
        $display("errors: %0d value, %0d sequence, %0d timeout, %0d input file",
                 value_errors, sequence_errors, timeout_errors, load_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end
        else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/program_input.txt */
# I <instruction word, hex>  loaded in order from address 0
# S <store address, hex> <store data, hex>  in the order the stores must appear
I 00500093  # addi x1, x0, 5
I 00708113  # addi x2, x1, 7
I 002081B3  # add  x3, x1, x2
I 10302023  # sw   x3, 0x100(x0)
S 00000100 00000011
I 40118233  # sub  x4, x3, x1
I 10402223  # sw   x4, 0x104(x0)
S 00000104 0000000C
I ABCDE2B7  # lui  x5, 0xabcde
I 12328293  # addi x5, x5, 0x123
I 10502423  # sw   x5, 0x108(x0)
S 00000108 ABCDE123
I 0032C333  # xor  x6, x5, x3
I 005373B3  # and  x7, x6, x5
I 0013E433  # or   x8, x7, x1
I 10802623  # sw   x8, 0x10c(x0)
S 0000010C ABCDE127
I 1060A6A3  # sw   x6, 0x10d(x1) low address bits are dropped
S 00000110 ABCDE132
I FFF00493  # addi x9, x0, -1
I 00049663  # bne  x9, x0, +12 taken
I 1E902823  # sw   x9, 0x1f0(x0) skipped
I 1E902A23  # sw   x9, 0x1f4(x0) skipped
I 00408463  # beq  x1, x4, +8 not taken
I 10902A23  # sw   x9, 0x114(x0)
S 00000114 FFFFFFFF
I 00410463  # beq  x2, x4, +8 taken
I 1E002C23  # sw   x0, 0x1f8(x0) skipped
I 40900533  # sub  x10, x0, x9
I 00948033  # add  x0, x9, x9
I 00A005B3  # add  x11, x0, x10
I 10B02C23  # sw   x11, 0x118(x0)
S 00000118 00000001
I 10002E23  # sw   x0, 0x11c(x0)
S 0000011C 00000000
I 00000063  # beq  x0, x0, 0 final self-loop

/* verilog.f */
+incdir+common
common/core_pkg.sv
common/stage_if.sv
decode/regbank.sv
decode/decode.sv
verilog/fetch.sv
verilog/execute.sv
verilog/retire.sv
verilog/rv32_core.sv
verif/core_checker.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: rv32_core

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - common/stage_if.sv
      - decode/regbank.sv
      - decode/decode.sv
      - verilog/fetch.sv
      - verilog/execute.sv
      - verilog/retire.sv
      - verilog/rv32_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/core_checker.sv
      - verif/core_tb.sv
